//--- verilog/lvda_defines.svh
`ifndef LVDA_DEFINES_SVH
`define LVDA_DEFINES_SVH

// Bit timing.
`define LVDA_BIT_DIV 4          // Clocks per serial bit and per filter sample.
`define LVDA_FILT_LEN 3         // Equal samples before a new level is taken.

// Computer interface widths.
`define LVDA_WORD_W 26
`define LVDA_ADDR_W 9

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Process I/O address codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LVDA_ADDR_DIN_LO   9'h004
`define LVDA_ADDR_DIN_HI   9'h008
`define LVDA_ADDR_DIS      9'h010
`define LVDA_ADDR_INTR     9'h0A0
`define LVDA_ADDR_HALT_CLR 9'h0B4

`endif

//--- verilog/lvda_io_pkg.sv
package lvda_io_pkg;

    // Field side discrete groups.
    typedef logic [23:0] din_word_t;
    typedef logic [7:0]  dis_word_t;
    typedef logic [6:0]  intr_vec_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit-time phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One hot, rotating w, x, y, z.
    typedef struct packed {
        logic w;
        logic x;
        logic y;
        logic z;
    } phase_t;

endpackage

//--- verilog/lvda_pio_pkg.sv
`include "lvda_defines.svh"

package lvda_pio_pkg;

    // Process I/O command from the computer.
    typedef struct packed {
        logic [`LVDA_ADDR_W-1:0] addr;
        logic                    strobe;    // One cycle.
    } pio_cmd_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded functions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // At most one pulse high.
    typedef struct packed {
        logic rd_din_lo;
        logic rd_din_hi;
        logic rd_dis;
        logic rd_intr;
        logic halt_clr;
    } pio_func_t;

    // Word sent back to the computer.
    typedef logic [`LVDA_WORD_W-1:0] lvdc_word_t;

endpackage

//--- verilog/lvda_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "lvda_defines.svh"

module lvda_timing (
    input  logic                sim_clk,
    input  logic                arst_n,
    output lvda_io_pkg::phase_t phase
);
    localparam int CW = $clog2(`LVDA_BIT_DIV);

    logic [CW-1:0] ph_cnt;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            ph_cnt <= '0;   // Phase w.
        end else if (ph_cnt == CW'(`LVDA_BIT_DIV - 1)) begin
            ph_cnt <= '0;
        end else begin
            ph_cnt <= ph_cnt + 1'b1;
        end
    end

    // Strobe decode.
    always_comb begin
        phase.w = (ph_cnt == CW'(0));
        phase.x = (ph_cnt == CW'(1));
        phase.y = (ph_cnt == CW'(2));
        phase.z = (ph_cnt == CW'(3));
    end

endmodule
`default_nettype wire

//--- verilog/input_filter.sv
`timescale 1ns/1ps
`default_nettype none
`include "lvda_defines.svh"

module input_filter #(
    parameter type payload_t = logic
) (
    input  logic                sim_clk,
    input  logic                arst_n,
    input  lvda_io_pkg::phase_t phase,
    input  payload_t            raw,
    output payload_t            clean
);
    localparam int W  = $bits(payload_t);
    localparam int CW = $clog2(`LVDA_FILT_LEN);

    logic [W-1:0] meta;
    logic [W-1:0] sync;
    logic [W-1:0] filt;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            meta <= '0;
            sync <= '0;
        end else begin
            meta <= raw;
            sync <= meta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-bit agreement filter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < W; i++) begin : g_bit
        logic [CW-1:0] agree;   // Samples seen that differ from output.
        logic          q;

        always_ff @(posedge sim_clk or negedge arst_n) begin
            if (!arst_n) begin
                agree <= '0;
                q     <= 1'b0;
            end else if (phase.z) begin
                if (sync[i] == q) begin
                    agree <= '0;    // Transient gone.
                end else if (agree == CW'(`LVDA_FILT_LEN - 1)) begin
                    agree <= '0;
                    q     <= sync[i];
                end else begin
                    agree <= agree + 1'b1;
                end
            end
        end

        assign filt[i] = q;
    end

    assign clean = payload_t'(filt);

endmodule
`default_nettype wire

//--- verilog/address_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "lvda_defines.svh"

module address_decode (
    input  logic                    sim_clk,
    input  logic                    arst_n,
    input  lvda_pio_pkg::pio_cmd_t  pio,
    output lvda_pio_pkg::pio_func_t func
);
    import lvda_pio_pkg::*;

    pio_func_t func_next;

    // Address compare, only on a strobe.
    always_comb begin
        func_next = '0;
        if (pio.strobe) begin
            case (pio.addr)
                `LVDA_ADDR_DIN_LO: begin
                    func_next.rd_din_lo = 1'b1;
                end
                `LVDA_ADDR_DIN_HI: begin
                    func_next.rd_din_hi = 1'b1;
                end
                `LVDA_ADDR_DIS: begin
                    func_next.rd_dis = 1'b1;
                end
                `LVDA_ADDR_INTR: begin
                    func_next.rd_intr = 1'b1;
                end
                `LVDA_ADDR_HALT_CLR: begin
                    func_next.halt_clr = 1'b1;
                end
                default: begin
                    func_next = '0;     // Unknown code.
                end
            endcase
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            func <= '0;
        end else begin
            func <= func_next;  // Pulse one cycle after strobe.
        end
    end

endmodule
`default_nettype wire

//--- verilog/interrupt_register.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_register (
    input  logic                   sim_clk,
    input  logic                   arst_n,
    input  lvda_io_pkg::intr_vec_t intr,
    input  logic                   rd_intr,
    output lvda_io_pkg::intr_vec_t pending,
    output logic                   intc
);
    import lvda_io_pkg::*;

    intr_vec_t intr_d;
    intr_vec_t rise;
    intr_vec_t pend_next;

    assign rise = intr & ~intr_d;

    // New edges win over the read clear.
    assign pend_next = (rd_intr ? '0 : pending) | rise;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            intr_d  <= '0;
            pending <= '0;
            intc    <= 1'b0;
        end else begin
            intr_d  <= intr;
            pending <= pend_next;
            intc    <= |pend_next;
        end
    end

endmodule
`default_nettype wire

//--- verilog/data_serializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lvda_defines.svh"

module data_serializer (
    input  logic                    sim_clk,
    input  logic                    arst_n,
    input  lvda_io_pkg::phase_t     phase,
    input  lvda_pio_pkg::pio_func_t func,
    input  lvda_io_pkg::din_word_t  din,
    input  lvda_io_pkg::dis_word_t  dis,
    input  lvda_io_pkg::intr_vec_t  pending,
    output logic                    data,
    output logic                    busy
);
    import lvda_io_pkg::*;
    import lvda_pio_pkg::*;

    localparam int NW = `LVDA_WORD_W;
    localparam int BW = $clog2(`LVDA_WORD_W);
    localparam int HW = $bits(din_word_t) / 2;

    lvdc_word_t    sel_word;
    lvdc_word_t    shreg;
    logic          rd_any;
    logic          armed;       // Word loaded and waiting for phase w.
    logic [BW-1:0] bit_cnt;

    assign rd_any = func.rd_din_lo | func.rd_din_hi | func.rd_dis | func.rd_intr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Zero-extended word select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sel_word = '0;
        if (func.rd_din_lo) begin
            sel_word = {{(NW - HW){1'b0}}, din[HW-1:0]};
        end else if (func.rd_din_hi) begin
            sel_word = {{(NW - HW){1'b0}}, din[2*HW-1:HW]};
        end else if (func.rd_dis) begin
            sel_word = {{(NW - $bits(dis_word_t)){1'b0}}, dis};
        end else if (func.rd_intr) begin
            sel_word = {{(NW - $bits(intr_vec_t)){1'b0}}, pending};
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            armed   <= 1'b0;
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (phase.w) begin
                if (bit_cnt == BW'(NW - 1)) begin
                    busy    <= 1'b0;    // Last bit done.
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else if (phase.w && (armed || rd_any)) begin
            busy  <= 1'b1;
            armed <= 1'b0;
        end else if (rd_any) begin
            armed <= 1'b1;
        end
    end

    // Shift out MSB first.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg <= '0;
        end else if (!busy && rd_any) begin
            shreg <= sel_word;
        end else if (busy && phase.w) begin
            shreg <= {shreg[NW-2:0], 1'b0};
        end
    end

    assign data = shreg[NW-1];  // Empty once the last bit is out.

endmodule
`default_nettype wire

//--- verilog/halt_control.sv
`timescale 1ns/1ps
`default_nettype none

module halt_control (
    input  logic sim_clk,
    input  logic arst_n,
    input  logic hlt,
    input  logic halt_clr,
    input  logic cst,
    output logic halt,
    output logic cstn
);
    logic cst_m;
    logic cst_s;
    logic cst_d;
    logic cst_rise;

    assign cst_rise = cst_s & ~cst_d;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            cst_m <= 1'b0;
            cst_s <= 1'b0;
            cst_d <= 1'b0;
            halt  <= 1'b0;
        end else begin
            cst_m <= cst;
            cst_s <= cst_m;
            cst_d <= cst_s;
            if (hlt) begin
                halt <= 1'b1;   // Halt line overrides clears.
            end else if (halt_clr || cst_rise) begin
                halt <= 1'b0;
            end
        end
    end

    assign cstn = ~cst_s;   // Start, two cycles late.

endmodule
`default_nettype wire

//--- verilog/lvda.sv
`timescale 1ns/1ps
`default_nettype none

module lvda (
    input  logic                   sim_clk,
    input  logic                   arst_n,
    input  lvda_pio_pkg::pio_cmd_t pio,
    input  lvda_io_pkg::din_word_t din_x,
    input  lvda_io_pkg::dis_word_t dis_x,
    input  lvda_io_pkg::intr_vec_t intr_x,
    input  logic                   hltx,
    input  logic                   cst,
    output logic                   data,
    output logic                   busy,
    output logic                   intc,
    output logic                   halt,
    output logic                   cstn
);
    import lvda_io_pkg::*;
    import lvda_pio_pkg::*;

    phase_t    phase;
    din_word_t din;
    dis_word_t dis;
    intr_vec_t intr;
    intr_vec_t pending;
    logic      hlt;
    pio_func_t func;

    lvda_timing u_timing (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field input conditioning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    input_filter #(.payload_t(din_word_t)) u_din_filt (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .raw     (din_x),
        .clean   (din)
    );

    input_filter #(.payload_t(dis_word_t)) u_dis_filt (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .raw     (dis_x),
        .clean   (dis)
    );

    input_filter #(.payload_t(intr_vec_t)) u_intr_filt (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .raw     (intr_x),
        .clean   (intr)
    );

    input_filter #(.payload_t(logic)) u_hlt_filt (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .raw     (hltx),
        .clean   (hlt)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Computer side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    address_decode u_decode (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .pio     (pio),
        .func    (func)
    );

    interrupt_register u_intr_reg (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .intr    (intr),
        .rd_intr (func.rd_intr),
        .pending (pending),
        .intc    (intc)
    );

    data_serializer u_serializer (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .func    (func),
        .din     (din),
        .dis     (dis),
        .pending (pending),
        .data    (data),
        .busy    (busy)
    );

    halt_control u_halt (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .hlt      (hlt),
        .halt_clr (func.halt_clr),
        .cst      (cst),
        .halt     (halt),
        .cstn     (cstn)
    );

endmodule
`default_nettype wire

//--- verif/lvda_asserts.sv
`timescale 1ns/1ps
`include "lvda_defines.svh"

module lvda_asserts (
    input logic                   sim_clk,
    input logic                   arst_n,
    input lvda_pio_pkg::pio_cmd_t pio,
    input lvda_io_pkg::phase_t    phase,
    input logic                   busy,
    input logic                   data
);
    localparam int BUSY_LEN = `LVDA_WORD_W * `LVDA_BIT_DIV;

    logic [7:0] busy_len;   // Cycles busy has been high so far.

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_len <= '0;
        end else if (busy) begin
            busy_len <= busy_len + 1'b1;
        end else begin
            busy_len <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol and timing properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Commands are not queued.
    a_no_strobe_busy: assert property (@(posedge sim_clk) disable iff (!arst_n)
        busy |-> !pio.strobe)
        else $error("command strobe issued while busy is high");

    a_phase_onehot: assert property (@(posedge sim_clk) disable iff (!arst_n)
        $onehot(phase))
        else $error("phase strobes are not one-hot");

    a_busy_max: assert property (@(posedge sim_clk) disable iff (!arst_n)
        busy |-> (busy_len < 8'(BUSY_LEN)))
        else $error("busy held longer than one word time");

    a_busy_len: assert property (@(posedge sim_clk) disable iff (!arst_n)
        $fell(busy) |-> (busy_len == 8'(BUSY_LEN)))
        else $error("busy dropped before the whole word was sent");

    a_data_idle: assert property (@(posedge sim_clk) disable iff (!arst_n)
        !busy |-> !data)
        else $error("data high while busy is low");

endmodule

//--- verif/tb_lvda.sv
`timescale 1ns/1ps
`include "lvda_defines.svh"

module tb_lvda;
    import lvda_io_pkg::*;
    import lvda_pio_pkg::*;

    typedef logic [`LVDA_ADDR_W-1:0] addr_t;

    localparam int SEED           = 72386;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int SETTLE_NS      = 1;      // Drive and sample point after the edge.
    localparam int FILT_WAIT      = 24;     // Worst filter latency plus margin.

    logic      sim_clk;
    logic      arst_n;
    pio_cmd_t  pio;
    din_word_t din_x;
    dis_word_t dis_x;
    intr_vec_t intr_x;
    logic      hltx;
    logic      cst;
    logic      data;
    logic      busy;
    logic      intc;
    logic      halt;
    logic      cstn;

    int unsigned cycles     = 0;
    bit          run_ok     = 1'b0;
    bit          fail_shown = 1'b0;

    lvda u_lvda (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .pio     (pio),
        .din_x   (din_x),
        .dis_x   (dis_x),
        .intr_x  (intr_x),
        .hltx    (hltx),
        .cst     (cst),
        .data    (data),
        .busy    (busy),
        .intc    (intc),
        .halt    (halt),
        .cstn    (cstn)
    );

    bind lvda lvda_asserts u_lvda_asserts (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .pio     (pio),
        .phase   (phase),
        .busy    (busy),
        .data    (data)
    );

    initial begin
        sim_clk = 1'b0;
        forever #2 sim_clk = ~sim_clk;
    end

    always @(posedge sim_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles.", cycles);
            stop_on_error();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_error();
        fail_shown = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input lvdc_word_t exp, input lvdc_word_t got);
        assert (got === exp) else begin
            $display("ERR %0t %s expected 0x%07h actual 0x%07h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic step_cycle();
        @(posedge sim_clk);
        #SETTLE_NS;
    endtask

    task automatic wait_filter();
        repeat (FILT_WAIT) step_cycle();
    endtask

    task automatic issue_command(input addr_t addr);
        pio.addr   = addr;
        pio.strobe = 1'b1;      // One cycle.
        step_cycle();
        pio.strobe = 1'b0;
    endtask

    // Bit k sits on data from 4k to 4k+4 cycles after busy rises.
    task automatic read_word(input addr_t addr, output lvdc_word_t word);
        int k;
        word = '0;
        issue_command(addr);
        while (busy !== 1'b1) begin
            step_cycle();
        end
        repeat (2) step_cycle();
        for (k = 0; k < `LVDA_WORD_W; k++) begin
            word = {word[`LVDA_WORD_W-2:0], data};
            if (k != `LVDA_WORD_W - 1) begin
                repeat (`LVDA_BIT_DIV) step_cycle();
            end
        end
        while (busy !== 1'b0) begin
            step_cycle();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        din_word_t  din_val;
        dis_word_t  dis_val;
        intr_vec_t  intr_val;
        addr_t      bad_addr;
        lvdc_word_t word;

        void'($urandom(SEED));
        arst_n = 1'b0;
        pio    = '0;
        din_x  = '0;
        dis_x  = '0;
        intr_x = '0;
        hltx   = 1'b0;
        cst    = 1'b0;
        repeat (2) @(posedge sim_clk);
        #SETTLE_NS;
        arst_n = 1'b1;
        step_cycle();

        check_bit("busy", 1'b0, busy);     // Reset values.
        check_bit("data", 1'b0, data);
        check_bit("intc", 1'b0, intc);
        check_bit("halt", 1'b0, halt);
        check_bit("cstn", 1'b1, cstn);

        // Discrete inputs and status, zero extended.
        din_val = din_word_t'($urandom);
        dis_val = dis_word_t'($urandom);
        din_x   = din_val;
        dis_x   = dis_val;
        wait_filter();
        read_word(`LVDA_ADDR_DIN_LO, word);
        check_word("data word din_lo", lvdc_word_t'(din_val[11:0]), word);
        read_word(`LVDA_ADDR_DIN_HI, word);
        check_word("data word din_hi", lvdc_word_t'(din_val[23:12]), word);
        read_word(`LVDA_ADDR_DIS, word);
        check_word("data word dis", lvdc_word_t'(dis_val), word);

        intr_val = intr_vec_t'($urandom);
        while (intr_val == '0) begin
            intr_val = intr_vec_t'($urandom);
        end
        intr_x = intr_val;
        wait_filter();
        check_bit("intc", 1'b1, intc);
        read_word(`LVDA_ADDR_INTR, word);
        check_word("data word intr", lvdc_word_t'(intr_val), word);
        check_bit("intc", 1'b0, intc);     // Cleared by the read.

        bad_addr = addr_t'($urandom);
        while (bad_addr inside {`LVDA_ADDR_DIN_LO, `LVDA_ADDR_DIN_HI, `LVDA_ADDR_DIS,
                                `LVDA_ADDR_INTR, `LVDA_ADDR_HALT_CLR}) begin
            bad_addr = addr_t'($urandom);
        end
        issue_command(bad_addr);
        repeat (10) begin
            check_bit("busy", 1'b0, busy);
            step_cycle();
        end

        // Halt latch, start line, then the clear command.
        hltx = 1'b1;
        wait_filter();
        check_bit("halt", 1'b1, halt);
        hltx = 1'b0;
        wait_filter();
        check_bit("halt", 1'b1, halt);
        cst = 1'b1;
        step_cycle();
        check_bit("cstn", 1'b1, cstn);
        step_cycle();
        check_bit("cstn", 1'b0, cstn);
        cst = 1'b0;
        repeat (2) step_cycle();
        check_bit("halt", 1'b0, halt);
        check_bit("cstn", 1'b1, cstn);
        hltx = 1'b1;
        wait_filter();
        hltx = 1'b0;
        wait_filter();
        check_bit("halt", 1'b1, halt);
        issue_command(`LVDA_ADDR_HALT_CLR);
        step_cycle();
        check_bit("halt", 1'b0, halt);

        run_ok = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    final begin
        if (!run_ok && !fail_shown) begin
            $display("*** TEST FAILED ***");
        end
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/lvda_io_pkg.sv
verilog/lvda_pio_pkg.sv
verilog/lvda_timing.sv
verilog/input_filter.sv
verilog/address_decode.sv
verilog/interrupt_register.sv
verilog/data_serializer.sv
verilog/halt_control.sv
verilog/lvda.sv
verif/lvda_asserts.sv
verif/tb_lvda.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lvda testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_lvda \
    -Mdir obj_dir -o sim_lvda > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/sim_lvda > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q -F '*** TEST PASSED ***' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log."
exit 1
